/* Bender.yml */
package:
  name: mem_stage

sources:
  - common/mem_stage_pkg.sv
  - design/pipe_reg.sv
  - design/mem_access.sv
  - dmem/dmem_ram.sv
  - design/mem_stage.sv
  - target: test
    files:
      - sim/mem_stage_asserts.sv
      - sim/mem_stage_checker.sv
      - sim/tb_mem_stage.sv

/* common/mem_stage_pkg.sv */
package mem_stage_pkg;

    // Data path and address width.
    parameter int DATA_W = 32;
    parameter int REG_ADDR_W = 5;
    parameter int BE_W = DATA_W / 8;

    // Access operation of a request.
    typedef enum logic [1:0] {
        OP_PASS  = 2'b00, // Data straight to register.
        OP_LOAD  = 2'b01, // Memory to register.
        OP_STORE = 2'b10  // Register to memory.
    } access_op_e;

    // Access size of a request.
    typedef enum logic [1:0] {
        SZ_BYTE = 2'b00,
        SZ_HALF = 2'b01,
        SZ_WORD = 2'b10
    } access_sz_e;

    // One request from execute.
    typedef struct packed {
        access_op_e            op;
        access_sz_e            sz;
        logic                  is_unsigned; // Zero-extend loads.
        logic [DATA_W-1:0]     addr;
        logic [DATA_W-1:0]     data;        // Store or pass-through data.
        logic [REG_ADDR_W-1:0] reg_addr;
    } mem_req_t;

    // One record for write-back.
    typedef struct packed {
        logic [REG_ADDR_W-1:0] reg_addr;
        logic                  reg_we;      // Loads and pass-through only.
        logic [DATA_W-1:0]     data;
    } wb_rec_t;

endpackage

/* design/mem_access.sv */
`timescale 1ns/10ps

module mem_access (
    // Held request from the input register.
    input  logic                                req_valid_i,
    input  mem_stage_pkg::mem_req_t             req_i,
    output logic                                req_ready_o,

    // Data RAM side.
    output logic [31:0]                         mem_addr_o,
    output logic                                mem_wr_o,
    output logic [mem_stage_pkg::BE_W-1:0]      mem_be_o,
    output logic [mem_stage_pkg::DATA_W-1:0]    mem_wdata_o,
    input  logic [mem_stage_pkg::DATA_W-1:0]    mem_rdata_i,

    // Toward the write-back register.
    output logic                                wb_valid_o,
    output mem_stage_pkg::wb_rec_t              wb_o,
    input  logic                                wb_ready_i
);

    localparam int DW = mem_stage_pkg::DATA_W;

    logic          xfer;
    logic [7:0]    lane_byte;
    logic [15:0]   lane_half;
    logic [DW-1:0] load_data;

    // Handshake passes straight through.
    assign wb_valid_o  = req_valid_i;
    assign req_ready_o = wb_ready_i;
    assign xfer        = req_valid_i && wb_ready_i;

    assign mem_addr_o = req_i.addr;
    assign mem_wr_o   = xfer && (req_i.op == mem_stage_pkg::OP_STORE); // Once per store.

    always_comb begin
        case (req_i.sz)
            mem_stage_pkg::SZ_BYTE: mem_be_o = 4'b0001 << req_i.addr[1:0];
            mem_stage_pkg::SZ_HALF: mem_be_o = req_i.addr[1] ? 4'b1100 : 4'b0011;
            default:                mem_be_o = 4'b1111;
        endcase
    end

    // Replicate store data across lanes.
    always_comb begin
        case (req_i.sz)
            mem_stage_pkg::SZ_BYTE: mem_wdata_o = {4{req_i.data[7:0]}};
            mem_stage_pkg::SZ_HALF: mem_wdata_o = {2{req_i.data[15:0]}};
            default:                mem_wdata_o = req_i.data;
        endcase
    end

    assign lane_byte = mem_rdata_i[{req_i.addr[1:0], 3'b000} +: 8];
    assign lane_half = req_i.addr[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];

    always_comb begin
        case (req_i.sz)
            mem_stage_pkg::SZ_BYTE: begin
                if (req_i.is_unsigned) begin
                    load_data = {{(DW-8){1'b0}}, lane_byte};
                end else begin
                    load_data = {{(DW-8){lane_byte[7]}}, lane_byte};
                end
            end
            mem_stage_pkg::SZ_HALF: begin
                if (req_i.is_unsigned) begin
                    load_data = {{(DW-16){1'b0}}, lane_half};
                end else begin
                    load_data = {{(DW-16){lane_half[15]}}, lane_half};
                end
            end
            default: load_data = mem_rdata_i; // Whole word.
        endcase
    end

    always_comb begin
        wb_o.reg_addr = req_i.reg_addr;
        case (req_i.op)
            mem_stage_pkg::OP_LOAD: begin
                wb_o.reg_we = 1'b1;
                wb_o.data   = load_data;
            end
            mem_stage_pkg::OP_STORE: begin
                wb_o.reg_we = 1'b0;
                wb_o.data   = req_i.data;
            end
            default: begin
                // Pass-through.
                wb_o.reg_we = 1'b1;
                wb_o.data   = req_i.data;
            end
        endcase
    end

endmodule

/* design/mem_stage.sv */
`timescale 1ns/10ps

module mem_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                       clk_i,
    input  logic                       rst_i,

    input  logic                       req_valid_i,
    input  mem_stage_pkg::mem_req_t    req_i,
    output logic                       req_ready_o,

    output logic                       wb_valid_o,
    output mem_stage_pkg::wb_rec_t     wb_o,
    input  logic                       wb_ready_i
);

    // Held request.
    logic                    held_valid;
    logic                    held_ready;
    mem_stage_pkg::mem_req_t held_req;

    // Record into the write-back register.
    logic                    rec_valid;
    logic                    rec_ready;
    mem_stage_pkg::wb_rec_t  rec;

    logic [31:0]                        mem_addr;
    logic                               mem_wr;
    logic [mem_stage_pkg::BE_W-1:0]     mem_be;
    logic [mem_stage_pkg::DATA_W-1:0]   mem_wdata;
    logic [mem_stage_pkg::DATA_W-1:0]   mem_rdata;

    pipe_reg #(
        .T (mem_stage_pkg::mem_req_t)
    ) u_req_reg (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (req_valid_i),
        .data_i  (req_i),
        .ready_o (req_ready_o),
        .valid_o (held_valid),
        .data_o  (held_req),
        .ready_i (held_ready)
    );

    mem_access u_access (
        .req_valid_i (held_valid),
        .req_i       (held_req),
        .req_ready_o (held_ready),
        .mem_addr_o  (mem_addr),
        .mem_wr_o    (mem_wr),
        .mem_be_o    (mem_be),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata),
        .wb_valid_o  (rec_valid),
        .wb_o        (rec),
        .wb_ready_i  (rec_ready)
    );

    dmem_ram #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_dmem (
        .clk_i   (clk_i),
        .addr_i  (mem_addr),
        .wr_i    (mem_wr),
        .be_i    (mem_be),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

    pipe_reg #(
        .T (mem_stage_pkg::wb_rec_t)
    ) u_wb_reg (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (rec_valid),
        .data_i  (rec),
        .ready_o (rec_ready),
        .valid_o (wb_valid_o),
        .data_o  (wb_o),
        .ready_i (wb_ready_i)
    );

endmodule

/* design/pipe_reg.sv */
`timescale 1ns/10ps

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk_i,
    input  logic rst_i,

    input  logic valid_i,
    input  T     data_i,
    output logic ready_o,

    output logic valid_o,
    output T     data_o,
    input  logic ready_i
);

    logic valid_q;
    logic load;
    T     data_q;

    // Free slot, or the held item leaves this cycle.
    assign ready_o = !valid_q || ready_i;
    assign load    = valid_i && ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

/* dmem/dmem_ram.sv */
`timescale 1ns/10ps

module dmem_ram #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                                clk_i,
    input  logic [31:0]                         addr_i,
    input  logic                                wr_i,
    input  logic [mem_stage_pkg::BE_W-1:0]      be_i,
    input  logic [mem_stage_pkg::DATA_W-1:0]    wdata_i,
    output logic [mem_stage_pkg::DATA_W-1:0]    rdata_o
);

    localparam int AW = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;
    localparam int NB = mem_stage_pkg::BE_W;

    logic [mem_stage_pkg::DATA_W-1:0] mem_q [DMEM_WORDS];
    logic [AW-1:0]                    word_idx;

    // Word index wraps at the depth.
    assign word_idx = AW'(addr_i[31:2] % DMEM_WORDS);

    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            for (int b = 0; b < NB; b++) begin
                if (be_i[b]) begin
                    mem_q[word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    assign rdata_o = mem_q[word_idx]; // Asynchronous read.

endmodule

/* mem_stage.f */
common/mem_stage_pkg.sv
design/pipe_reg.sv
design/mem_access.sv
dmem/dmem_ram.sv
design/mem_stage.sv
sim/mem_stage_asserts.sv
sim/mem_stage_checker.sv
sim/tb_mem_stage.sv

/* sim/mem_stage_asserts.sv */
`timescale 1ns/10ps

module mem_stage_asserts #(
    parameter int W = 1
) (
    input logic         clk_i,
    input logic         rst_i,
    input logic         in_valid_i,
    input logic [W-1:0] in_data_i,
    input logic         in_ready_i,
    input logic         out_valid_i,
    input logic [W-1:0] out_data_i,
    input logic         out_ready_i
);

    int fail_cnt = 0; // Failures seen so far.

    in_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        in_valid_i && !in_ready_i |=> in_valid_i && $stable(in_data_i))
        else begin
            fail_cnt++;
            $error("input valid or payload changed while the register was stalled");
        end

    out_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
        else begin
            fail_cnt++;
            $error("output valid or payload changed while the consumer stalled");
        end

    reset_empty: assert property (@(posedge clk_i) rst_i |=> !out_valid_i)
        else begin
            fail_cnt++;
            $error("register holds a valid item right after reset");
        end

endmodule

bind pipe_reg mem_stage_asserts #(
    .W ($bits(T))
) u_asserts (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (valid_i),
    .in_data_i   (data_i),
    .in_ready_i  (ready_o),
    .out_valid_i (valid_o),
    .out_data_i  (data_o),
    .out_ready_i (ready_i)
);

/* sim/mem_stage_checker.sv */
`timescale 1ns/10ps

module mem_stage_checker (
    input  logic                   clk_i,
    input  logic                   rst_i,

    // Expectations ride along with each request.
    input  logic                   req_valid_i,
    input  logic                   req_ready_i,
    input  logic [127:0]           exp_name_i,
    input  mem_stage_pkg::wb_rec_t exp_rec_i,

    input  logic                   wb_valid_i,
    input  logic                   wb_ready_i,
    input  mem_stage_pkg::wb_rec_t wb_i,

    output int                     err_cnt_o,
    output int                     extra_cnt_o,
    output int                     pending_o
);

    typedef struct packed {
        logic [127:0]           name;
        mem_stage_pkg::wb_rec_t rec;
    } exp_t;

    exp_t exp_q[$];
    exp_t head;
    logic rst_d = 1'b0;
    int   err_cnt = 0;
    int   extra_cnt = 0;
    int   pending = 0;

    assign err_cnt_o   = err_cnt;
    assign extra_cnt_o = extra_cnt;
    assign pending_o   = pending;

    always @(posedge clk_i) begin
        rst_d <= rst_i;
        if (rst_d && !rst_i) begin
            // First edge out of reset.
            if (wb_valid_i !== 1'b0) begin
                err_cnt++;
                $display("error after_reset: expected wb_valid_o 0 actual %b", wb_valid_i);
            end
            if (req_ready_i !== 1'b1) begin
                err_cnt++;
                $display("error after_reset: expected req_ready_o 1 actual %b", req_ready_i);
            end
        end
        if (!rst_i) begin
            if (wb_valid_i && wb_ready_i) begin
                if (exp_q.size() == 0) begin
                    extra_cnt++;
                    $display("record for register %0d arrived with no request waiting for it",
                             wb_i.reg_addr);
                end else begin
                    head = exp_q.pop_front();
                    if (wb_i !== head.rec) begin
                        err_cnt++;
                        $display("error %0s: expected rd=%0d we=%b data=%h actual rd=%0d we=%b data=%h",
                                 head.name, head.rec.reg_addr, head.rec.reg_we, head.rec.data,
                                 wb_i.reg_addr, wb_i.reg_we, wb_i.data);
                    end
                end
            end
            if (req_valid_i && req_ready_i) begin
                exp_q.push_back({exp_name_i, exp_rec_i});
            end
        end
        pending <= exp_q.size();
    end

endmodule

/* sim/tb_mem_stage.sv */
`timescale 1ns/10ps

module tb_mem_stage;

    localparam mem_stage_pkg::access_op_e LD = mem_stage_pkg::OP_LOAD;
    localparam mem_stage_pkg::access_op_e ST = mem_stage_pkg::OP_STORE;
    localparam mem_stage_pkg::access_op_e PS = mem_stage_pkg::OP_PASS;
    localparam mem_stage_pkg::access_sz_e BY = mem_stage_pkg::SZ_BYTE;
    localparam mem_stage_pkg::access_sz_e HA = mem_stage_pkg::SZ_HALF;
    localparam mem_stage_pkg::access_sz_e WO = mem_stage_pkg::SZ_WORD;

    typedef struct {
        logic [127:0]             name;
        mem_stage_pkg::mem_req_t  req;
        mem_stage_pkg::wb_rec_t   exp;
    } vec_t;

    logic clk_i;
    logic rst_i;
    logic req_valid;
    logic req_ready_o;
    logic wb_valid_o;
    logic wb_ready;
    logic built = 1'b0;
    logic [127:0]            exp_name;
    logic [31:0]             lfsr_q = 32'h0057_a600;
    mem_stage_pkg::mem_req_t req;
    mem_stage_pkg::wb_rec_t  wb_o;
    mem_stage_pkg::wb_rec_t  exp_rec;
    int   err_cnt;
    int   extra_cnt;
    int   pending;
    vec_t tbl[$];

    mem_stage #(
        .DMEM_WORDS (64)
    ) dut_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (req_valid),
        .req_i       (req),
        .req_ready_o (req_ready_o),
        .wb_valid_o  (wb_valid_o),
        .wb_o        (wb_o),
        .wb_ready_i  (wb_ready)
    );

    mem_stage_checker u_checker (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (req_valid),
        .req_ready_i (req_ready_o),
        .exp_name_i  (exp_name),
        .exp_rec_i   (exp_rec),
        .wb_valid_i  (wb_valid_o),
        .wb_ready_i  (wb_ready),
        .wb_i        (wb_o),
        .err_cnt_o   (err_cnt),
        .extra_cnt_o (extra_cnt),
        .pending_o   (pending)
    );

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1.
    function automatic logic take_bit();
        lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
        return lfsr_q[0];
    endfunction

    task automatic add_test(input logic [127:0] name, input mem_stage_pkg::access_op_e op,
                            input mem_stage_pkg::access_sz_e sz, input logic uns,
                            input logic [31:0] addr, input logic [31:0] data,
                            input logic [31:0] exp_data, input logic exp_we);
        vec_t v;
        v.name            = name;
        v.req.op          = op;
        v.req.sz          = sz;
        v.req.is_unsigned = uns;
        v.req.addr        = addr;
        v.req.data        = data;
        v.req.reg_addr    = 5'(tbl.size() % 31 + 1);
        v.exp.reg_addr    = v.req.reg_addr;
        v.exp.reg_we      = exp_we;
        v.exp.data        = exp_data;
        tbl.push_back(v);
    endtask

    task automatic build_table();
        add_test("st_w0", ST, WO, 1'b0, 32'h10, 32'h1234_5678, 32'h1234_5678, 1'b0);
        add_test("st_w1", ST, WO, 1'b0, 32'h14, 32'hCAFE_F00D, 32'hCAFE_F00D, 1'b0);
        add_test("ld_w0", LD, WO, 1'b0, 32'h10, 32'h0, 32'h1234_5678, 1'b1);
        add_test("ld_w1", LD, WO, 1'b0, 32'h14, 32'h0, 32'hCAFE_F00D, 1'b1);
        // Upper data bits must not leak into other lanes.
        add_test("st_b0", ST, BY, 1'b0, 32'h20, 32'hAAAA_AA11, 32'hAAAA_AA11, 1'b0);
        add_test("st_b1", ST, BY, 1'b0, 32'h21, 32'hAAAA_AA22, 32'hAAAA_AA22, 1'b0);
        add_test("st_b2", ST, BY, 1'b0, 32'h22, 32'hAAAA_AA33, 32'hAAAA_AA33, 1'b0);
        add_test("st_b3", ST, BY, 1'b0, 32'h23, 32'hAAAA_AA44, 32'hAAAA_AA44, 1'b0);
        add_test("ld_bytes", LD, WO, 1'b0, 32'h20, 32'h0, 32'h4433_2211, 1'b1);
        add_test("st_sx", ST, WO, 1'b0, 32'h30, 32'h80F0_FF81, 32'h80F0_FF81, 1'b0);
        add_test("lb0_s", LD, BY, 1'b0, 32'h30, 32'h0, 32'hFFFF_FF81, 1'b1);
        add_test("lb1_s", LD, BY, 1'b0, 32'h31, 32'h0, 32'hFFFF_FFFF, 1'b1);
        add_test("lb2_s", LD, BY, 1'b0, 32'h32, 32'h0, 32'hFFFF_FFF0, 1'b1);
        add_test("lb3_s", LD, BY, 1'b0, 32'h33, 32'h0, 32'hFFFF_FF80, 1'b1);
        add_test("lb0_u", LD, BY, 1'b1, 32'h30, 32'h0, 32'h0000_0081, 1'b1);
        add_test("lb1_u", LD, BY, 1'b1, 32'h31, 32'h0, 32'h0000_00FF, 1'b1);
        add_test("lb2_u", LD, BY, 1'b1, 32'h32, 32'h0, 32'h0000_00F0, 1'b1);
        add_test("lb3_u", LD, BY, 1'b1, 32'h33, 32'h0, 32'h0000_0080, 1'b1);
        add_test("lh0_s", LD, HA, 1'b0, 32'h30, 32'h0, 32'hFFFF_FF81, 1'b1);
        add_test("lh1_s", LD, HA, 1'b0, 32'h32, 32'h0, 32'hFFFF_80F0, 1'b1);
        add_test("lh0_u", LD, HA, 1'b1, 32'h30, 32'h0, 32'h0000_FF81, 1'b1);
        add_test("lh1_u", LD, HA, 1'b1, 32'h32, 32'h0, 32'h0000_80F0, 1'b1);
        add_test("st_hbase", ST, WO, 1'b0, 32'h40, 32'h0, 32'h0, 1'b0);
        add_test("st_hhi", ST, HA, 1'b0, 32'h42, 32'h5555_BEEF, 32'h5555_BEEF, 1'b0);
        add_test("ld_half", LD, WO, 1'b0, 32'h40, 32'h0, 32'hBEEF_0000, 1'b1);
        add_test("pass", PS, WO, 1'b0, 32'h0, 32'hDEAD_BEEF, 32'hDEAD_BEEF, 1'b1);
        add_test("st_b2b", ST, WO, 1'b0, 32'h50, 32'h0BAD_CAFE, 32'h0BAD_CAFE, 1'b0);
        add_test("ld_b2b", LD, WO, 1'b0, 32'h50, 32'h0, 32'h0BAD_CAFE, 1'b1);
    endtask

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    initial begin
        wait (built);
        repeat (tbl.size() * 20) @(posedge clk_i);
        $display("watchdog expired before all write-back records came out");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int   idx;
        int   drain;
        int   asrt;
        logic sent;
        build_table();
        built = 1'b1;
        rst_i     <= 1'b1;
        req_valid <= 1'b0;
        req       <= '0;
        wb_ready  <= 1'b0;
        exp_name  <= '0;
        exp_rec   <= '0;
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;
        idx = 0;
        while (idx < tbl.size()) begin
            @(posedge clk_i);
            sent = req_valid && req_ready_o;
            if (sent) begin
                idx++;
            end
            if (!req_valid || sent) begin
                if (idx < tbl.size() && (take_bit() || take_bit())) begin
                    req_valid <= 1'b1;
                    req       <= tbl[idx].req;
                    exp_name  <= tbl[idx].name;
                    exp_rec   <= tbl[idx].exp;
                end else begin
                    req_valid <= 1'b0;
                end
            end
            wb_ready <= take_bit() || take_bit();
        end
        // The checker's count lags one edge behind its queue.
        drain = 0;
        do begin
            @(posedge clk_i);
            wb_ready <= take_bit() || take_bit();
            drain++;
        end while (pending != 0 && drain < 100);
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        asrt = dut_i.u_req_reg.u_asserts.fail_cnt + dut_i.u_wb_reg.u_asserts.fail_cnt;
        if (pending != 0) begin
            $display("%0d expected write-back records never arrived", pending);
        end
        $display("summary: %0d value errors, %0d unexpected, %0d missing, %0d assertion failures",
                 err_cnt, extra_cnt, pending, asrt);
        if (err_cnt + extra_cnt + pending + asrt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
